// ==== project.f ====
src/leaf_pkg.sv
src/stream_fifo.sv
src/leaf_unpacker.sv
src/leaf_packer.sv
src/sum_kernel.sv
src/leaf_i3o2.sv
test/leaf_i3o2_checker.sv
test/leaf_i3o2_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the leaf testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module leaf_i3o2_tb -o leaf_sim \
    && out=$(./obj_dir/leaf_sim) ; echo "$out" \
    && echo "$out" | grep -q "Simulation completed successfully" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// ==== src/leaf_i3o2.sv ====
`timescale 1ns/1ps
module leaf_i3o2 (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [leaf_pkg::PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [leaf_pkg::PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  logic                             resend,
    input  logic                             ap_start
);
    import leaf_pkg::*;

    logic [NUM_IN_PORTS-1:0]                     wr_en;
    logic [PAYLOAD_BITS-1:0]                     wr_data;
    logic [NUM_OUT_PORTS-1:0]                    dest_valid;
    logic [NUM_OUT_PORTS-1:0][NUM_LEAF_BITS-1:0] dest_leaf;
    logic [NUM_OUT_PORTS-1:0][NUM_PORT_BITS-1:0] dest_port;
    logic                                        user_rst_n;
    logic                                        kernel_rst_n;
    logic [NUM_IN_PORTS-1:0]                     fifo_vld;
    logic [NUM_IN_PORTS-1:0]                     fifo_ack;
    logic [PAYLOAD_BITS-1:0]                     fifo_dout_1;
    logic [PAYLOAD_BITS-1:0]                     fifo_dout_2;
    logic [PAYLOAD_BITS-1:0]                     fifo_dout_3;
    logic [NUM_OUT_PORTS-1:0]                    kern_vld;
    logic [NUM_OUT_PORTS-1:0]                    kern_ack;
    logic [PAYLOAD_BITS-1:0]                     kern_dout_1;
    logic [PAYLOAD_BITS-1:0]                     kern_dout_2;

    // kernel waits for ap_start as well as the system reset.
    assign kernel_rst_n = rst_n && user_rst_n;

    leaf_unpacker unpacker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ap_start   (ap_start),
        .din_packet (din_leaf_bft2interface),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .dest_valid (dest_valid),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port),
        .user_rst_n (user_rst_n)
    );

    stream_fifo fifo_1 (.clk(clk), .rst_n(rst_n), .wr_en(wr_en[0]), .din(wr_data),
                        .vld(fifo_vld[0]), .dout(fifo_dout_1), .ack(fifo_ack[0]));
    stream_fifo fifo_2 (.clk(clk), .rst_n(rst_n), .wr_en(wr_en[1]), .din(wr_data),
                        .vld(fifo_vld[1]), .dout(fifo_dout_2), .ack(fifo_ack[1]));
    stream_fifo fifo_3 (.clk(clk), .rst_n(rst_n), .wr_en(wr_en[2]), .din(wr_data),
                        .vld(fifo_vld[2]), .dout(fifo_dout_3), .ack(fifo_ack[2]));

    sum_kernel kernel_i (
        .clk     (clk),
        .rst_n   (kernel_rst_n),
        .vld_in  (fifo_vld),
        .din_1   (fifo_dout_1),
        .din_2   (fifo_dout_2),
        .din_3   (fifo_dout_3),
        .ack_in  (fifo_ack),
        .vld_out (kern_vld),
        .dout_1  (kern_dout_1),
        .dout_2  (kern_dout_2),
        .ack_out (kern_ack)
    );

    leaf_packer packer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .resend     (resend),
        .vld_out    (kern_vld),
        .dout_1     (kern_dout_1),
        .dout_2     (kern_dout_2),
        .ack_out    (kern_ack),
        .dest_valid (dest_valid),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port),
        .packet     (dout_leaf_interface2bft)
    );

endmodule

// ==== src/leaf_packer.sv ====
`timescale 1ns/1ps
module leaf_packer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                resend,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]  vld_out,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]   dout_1,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]   dout_2,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]  ack_out,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]  dest_valid,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::NUM_PORT_BITS-1:0] dest_port,
    output logic [leaf_pkg::PACKET_BITS-1:0]    packet
);
    import leaf_pkg::*;

    logic [NUM_OUT_PORTS-1:0]                    eligible;
    logic [NUM_OUT_PORTS-1:0]                    grant;
    logic                                        sel;
    logic                                        last_grant;
    logic [PAYLOAD_BITS-1:0]                     sel_payload;
    logic [NUM_OUT_PORTS-1:0][NUM_ADDR_BITS-1:0] seq;

    // resend stalls every stream.
    assign eligible = vld_out & dest_valid & {NUM_OUT_PORTS{!resend}};

    always_comb begin
        if (&eligible) begin
            // tie goes to the port not served last.
            sel = !last_grant;
        end else begin
            sel = eligible[1];
        end
        grant = '0;
        if (eligible != '0) begin
            grant[sel] = 1'b1;
        end
    end

    assign ack_out     = grant;
    assign sel_payload = sel ? dout_2 : dout_1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            packet     <= '0;
            last_grant <= 1'b0;
            seq        <= '0;
        end else if (eligible != '0) begin
            packet      <= {1'b1, dest_leaf[sel], dest_port[sel], seq[sel], sel_payload};
            last_grant  <= sel;
            seq[sel]    <= seq[sel] + 1'b1;
        end else begin
            // idle link carries zeros.
            packet <= '0;
        end
    end

endmodule

// ==== src/leaf_pkg.sv ====
package leaf_pkg;

    // tree packet geometry.
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // field positions, valid on top, payload at the bottom.
    localparam int ADDR_LSB  = PAYLOAD_BITS;
    localparam int PORT_LSB  = ADDR_LSB + NUM_ADDR_BITS;
    localparam int LEAF_LSB  = PORT_LSB + NUM_PORT_BITS;
    localparam int VALID_BIT = LEAF_LSB + NUM_LEAF_BITS;

    // stream counts.
    localparam int NUM_IN_PORTS  = 3;
    localparam int NUM_OUT_PORTS = 2;

    // input FIFO sizing.
    localparam int FIFO_DEPTH    = 8;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

    // configuration word layout.
    localparam int OP_BITS      = 4;
    localparam int CFG_SEL_BIT  = 16;
    localparam int CFG_LEAF_LSB = 8;
    localparam int CFG_PORT_LSB = 0;

    typedef enum logic [OP_BITS-1:0] {
        op_nop        = 4'h0,
        op_set_dest   = 4'h1,
        op_clear_dest = 4'h2
    } cfg_op_e;

    typedef enum logic {
        ks_held    = 1'b0,
        ks_running = 1'b1
    } kernel_state_e;

endpackage

// ==== src/leaf_unpacker.sv ====
`timescale 1ns/1ps
module leaf_unpacker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ap_start,
    input  logic [leaf_pkg::PACKET_BITS-1:0]    din_packet,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   wr_en,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]   wr_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]  dest_valid,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::NUM_PORT_BITS-1:0] dest_port,
    output logic                                user_rst_n
);
    import leaf_pkg::*;

    logic                     pkt_valid;
    logic [NUM_PORT_BITS-1:0] pkt_port;
    logic                     cfg_hit;
    logic                     cfg_sel;
    cfg_op_e                  cfg_op;
    kernel_state_e            kernel_state;

    assign pkt_valid = din_packet[VALID_BIT];
    assign pkt_port  = din_packet[PORT_LSB +: NUM_PORT_BITS];
    assign wr_data   = din_packet[PAYLOAD_BITS-1:0];

    // port 0 is the configuration channel.
    assign cfg_hit = pkt_valid && (pkt_port == '0);
    assign cfg_op  = cfg_op_e'(wr_data[PAYLOAD_BITS-1 -: OP_BITS]);
    assign cfg_sel = wr_data[CFG_SEL_BIT];

    // ports 1 to 3 map onto FIFOs 0 to 2, anything higher falls through.
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            wr_en[i] = pkt_valid && (pkt_port == NUM_PORT_BITS'(i + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_valid <= '0;
        end else if (cfg_hit) begin
            case (cfg_op)
                op_set_dest:   dest_valid[cfg_sel] <= 1'b1;
                op_clear_dest: dest_valid[cfg_sel] <= 1'b0;
                default:       dest_valid <= dest_valid;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_hit && (cfg_op == op_set_dest)) begin
            dest_leaf[cfg_sel] <= wr_data[CFG_LEAF_LSB +: NUM_LEAF_BITS];
            dest_port[cfg_sel] <= wr_data[CFG_PORT_LSB +: NUM_PORT_BITS];
        end
    end

    // kernel held in reset until the first ap_start.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kernel_state <= ks_held;
        end else if (ap_start) begin
            kernel_state <= ks_running;
        end
    end

    assign user_rst_n = (kernel_state == ks_running);

endmodule

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps
module stream_fifo (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_en,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] din,
    output logic                              vld,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] dout,
    input  logic                              ack
);
    import leaf_pkg::*;

    logic [PAYLOAD_BITS-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic [FIFO_PTR_BITS:0]   count;
    logic                     push;
    logic                     pop;

    // show-ahead: head entry always visible.
    assign vld  = (count != '0);
    assign dout = mem[rd_ptr];

    // a write into a full FIFO is lost.
    assign push = wr_en && (count != (FIFO_PTR_BITS + 1)'(FIFO_DEPTH));
    assign pop  = ack && vld;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/sum_kernel.sv ====
`timescale 1ns/1ps
module sum_kernel (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]  vld_in,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]  din_1,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]  din_2,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]  din_3,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]  ack_in,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0] vld_out,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]  dout_1,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]  dout_2,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0] ack_out
);
    import leaf_pkg::*;

    logic                    take_sum;
    logic                    take_acc;
    logic [PAYLOAD_BITS-1:0] acc;

    // a slot refills when empty or being drained this cycle.
    assign take_sum = vld_in[0] && vld_in[1] && (!vld_out[0] || ack_out[0]);
    assign take_acc = vld_in[2] && (!vld_out[1] || ack_out[1]);

    // streams 1 and 2 only move as a pair.
    assign ack_in = {take_acc, take_sum, take_sum};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_out <= '0;
        end else begin
            if (take_sum) begin
                vld_out[0] <= 1'b1;
            end else if (ack_out[0]) begin
                vld_out[0] <= 1'b0;
            end
            if (take_acc) begin
                vld_out[1] <= 1'b1;
            end else if (ack_out[1]) begin
                vld_out[1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_sum) begin
            dout_1 <= din_1 + din_2;
        end
    end

    // running total of stream 3.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (take_acc) begin
            acc <= acc + din_3;
        end
    end

    assign dout_2 = acc;

endmodule

// ==== test/leaf_i3o2_checker.sv ====
`timescale 1ns/1ps
module leaf_i3o2_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             resend,
    input logic [leaf_pkg::PACKET_BITS-1:0] dout
);
    import leaf_pkg::*;

    // the link goes quiet one cycle after resend.
    resend_silences_link: assert property (@(posedge clk) disable iff (!rst_n)
        resend |=> (dout == '0))
        else $error("output packet not zero after resend");

    reset_release_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (dout == '0))
        else $error("output packet not zero after reset release");

    // no stale header bits without the valid flag.
    invalid_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !dout[VALID_BIT] |-> (dout == '0))
        else $error("output packet has bits set while its valid bit is low");

endmodule

bind leaf_i3o2 leaf_i3o2_checker checker_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .resend (resend),
    .dout   (dout_leaf_interface2bft)
);

// ==== test/leaf_i3o2_tb.sv ====
`timescale 1ns/1ps
module leaf_i3o2_tb;
    import leaf_pkg::*;

    // five tests, none longer than about 200 cycles.
    localparam int TEST_CYCLES    = 200;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES + 200;

    logic                   clk;
    logic                   rst_n;
    logic [PACKET_BITS-1:0] din;
    logic [PACKET_BITS-1:0] dout;
    logic                   resend;
    logic                   ap_start;

    logic [PACKET_BITS-1:0] out_q[$];
    int                     cyc_q[$];
    int                     cyc;
    int                     last_sent_cyc;
    int                     errors;
    int                     checks;
    int                     tests;
    integer                 seed;

    leaf_i3o2 dut_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // collect every valid packet with the cycle it was seen.
    always @(posedge clk) begin
        if (dout[VALID_BIT]) begin
            out_q.push_back(dout);
            cyc_q.push_back(cyc);
        end
    end

    function automatic logic [PACKET_BITS-1:0] make_packet(
        input logic [NUM_PORT_BITS-1:0] port, input logic [PAYLOAD_BITS-1:0] payload);
        return {1'b1, 5'd0, port, 7'd0, payload};
    endfunction

    function automatic logic [PAYLOAD_BITS-1:0] cfg_word(input cfg_op_e op, input logic sel,
        input logic [NUM_LEAF_BITS-1:0] leaf, input logic [NUM_PORT_BITS-1:0] port);
        return {op, 11'd0, sel, 3'd0, leaf, 4'd0, port};
    endfunction

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n    <= 1'b0;
        din      <= '0;
        resend   <= 1'b0;
        ap_start <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        out_q.delete();
        cyc_q.delete();
    endtask

    task automatic send_word(input logic [NUM_PORT_BITS-1:0] port,
                             input logic [PAYLOAD_BITS-1:0] payload);
        @(posedge clk);
        din <= make_packet(port, payload);
        last_sent_cyc = cyc;
    endtask

    task automatic idle_link(input int cycles);
        @(posedge clk);
        din <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        ap_start <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
    endtask

    task automatic wait_packets(input int n);
        int waited;
        waited = 0;
        while (out_q.size() < n && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (out_q.size() >= n) else begin
            $display("timed out waiting for %0d output packets, only %0d arrived",
                     n, out_q.size());
            errors++;
        end
    endtask

    task automatic check_packet(input logic [NUM_LEAF_BITS-1:0] leaf,
        input logic [NUM_PORT_BITS-1:0] port, input int seq,
        input logic [PAYLOAD_BITS-1:0] payload);
        logic [PACKET_BITS-1:0] got;
        logic [PACKET_BITS-1:0] exp;
        exp = {1'b1, leaf, port, NUM_ADDR_BITS'(seq), payload};
        if (out_q.size() == 0) begin
            check(1'b0, "expected packet missing");
        end else begin
            got = out_q.pop_front();
            void'(cyc_q.pop_front());
            check(got == exp, $sformatf("packet %h, expected %h", got, exp));
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset_hold();
        int e0;
        e0 = errors;
        apply_reset();
        check(dout == '0, "output not zero after reset");
        send_word(4'd1, 32'h11);
        send_word(4'd2, 32'h22);
        send_word(4'd3, 32'h33);
        idle_link(20);
        check(out_q.size() == 0, "output packet seen with no destination configured");
        // destinations set, but still no ap_start.
        send_word(4'd0, cfg_word(op_set_dest, 1'b0, 5'd3, 4'd1));
        send_word(4'd0, cfg_word(op_set_dest, 1'b1, 5'd5, 4'd2));
        send_word(4'd1, 32'h44);
        send_word(4'd2, 32'h55);
        send_word(4'd3, 32'h66);
        idle_link(20);
        check(out_q.size() == 0, "output packet seen while kernel held");
        report_test("reset_hold", e0);
    endtask

    task automatic test_sum_path();
        logic [PAYLOAD_BITS-1:0] a[5];
        logic [PAYLOAD_BITS-1:0] b[5];
        int                      first_cyc;
        int                      e0;
        e0 = errors;
        apply_reset();
        send_word(4'd0, cfg_word(op_set_dest, 1'b0, 5'd9, 4'd6));
        idle_link(0);
        pulse_start();
        for (int i = 0; i < 5; i++) begin
            a[i] = $random(seed);
            b[i] = $random(seed);
            send_word(4'd1, a[i]);
            send_word(4'd2, b[i]);
            if (i == 0) begin
                first_cyc = last_sent_cyc;
            end
        end
        idle_link(0);
        wait_packets(5);
        // sampled one edge after driving, then three cycles through.
        if (cyc_q.size() > 0) begin
            check(cyc_q[0] - first_cyc == 4, "first sum packet has wrong latency");
        end
        for (int i = 0; i < 5; i++) begin
            check_packet(5'd9, 4'd6, i, a[i] + b[i]);
        end
        report_test("sum_path", e0);
    endtask

    task automatic test_accumulate_path();
        logic [PAYLOAD_BITS-1:0] w[6];
        logic [PAYLOAD_BITS-1:0] total;
        logic [PAYLOAD_BITS-1:0] sum;
        logic [PACKET_BITS-1:0]  got;
        int                      k1;
        int                      k2;
        int                      e0;
        e0 = errors;
        apply_reset();
        send_word(4'd0, cfg_word(op_set_dest, 1'b0, 5'd2, 4'd1));
        send_word(4'd0, cfg_word(op_set_dest, 1'b1, 5'd17, 4'd3));
        idle_link(0);
        pulse_start();
        sum = 32'hffff_fff0 + 32'h25;
        send_word(4'd1, 32'hffff_fff0);
        send_word(4'd2, 32'h25);
        total = '0;
        k1 = 0;
        k2 = 0;
        for (int i = 0; i < 6; i++) begin
            w[i] = $random(seed);
            send_word(4'd3, w[i]);
        end
        idle_link(0);
        wait_packets(7);
        while (out_q.size() > 0) begin
            got = out_q.pop_front();
            void'(cyc_q.pop_front());
            if (got[LEAF_LSB +: NUM_LEAF_BITS] == 5'd17) begin
                total = total + w[k2];
                check(got == {1'b1, 5'd17, 4'd3, NUM_ADDR_BITS'(k2), total},
                      $sformatf("accumulate packet %h wrong", got));
                k2++;
            end else begin
                check(got == {1'b1, 5'd2, 4'd1, NUM_ADDR_BITS'(k1), sum},
                      $sformatf("sum packet %h wrong", got));
                k1++;
            end
        end
        check(k1 == 1 && k2 == 6, "wrong packet count per output");
        report_test("accumulate_path", e0);
    endtask

    task automatic test_resend_stall();
        logic [PAYLOAD_BITS-1:0] total;
        logic [PAYLOAD_BITS-1:0] w[4];
        int                      e0;
        e0 = errors;
        apply_reset();
        send_word(4'd0, cfg_word(op_set_dest, 1'b1, 5'd4, 4'd8));
        idle_link(0);
        pulse_start();
        resend <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            w[i] = 32'h100 * (i + 1) + i;
            send_word(4'd3, w[i]);
        end
        idle_link(10);
        check(out_q.size() == 0, "packet leaked while resend high");
        resend <= 1'b0;
        wait_packets(4);
        total = '0;
        for (int i = 0; i < 4; i++) begin
            total = total + w[i];
            check_packet(5'd4, 4'd8, i, total);
        end
        report_test("resend_stall", e0);
    endtask

    task automatic test_clear_dest();
        int e0;
        e0 = errors;
        apply_reset();
        send_word(4'd0, cfg_word(op_set_dest, 1'b0, 5'd7, 4'd2));
        idle_link(0);
        pulse_start();
        send_word(4'd1, 32'd10);
        send_word(4'd2, 32'd20);
        idle_link(0);
        wait_packets(1);
        check_packet(5'd7, 4'd2, 0, 32'd30);
        send_word(4'd0, cfg_word(op_clear_dest, 1'b0, 5'd0, 4'd0));
        send_word(4'd1, 32'd1);
        send_word(4'd2, 32'd2);
        send_word(4'd1, 32'd3);
        send_word(4'd2, 32'd4);
        idle_link(10);
        check(out_q.size() == 0, "packet sent on cleared output");
        send_word(4'd0, cfg_word(op_set_dest, 1'b0, 5'd30, 4'd5));
        idle_link(0);
        wait_packets(2);
        check_packet(5'd30, 4'd5, 1, 32'd3);
        check_packet(5'd30, 4'd5, 2, 32'd7);
        send_word(4'd0, cfg_word(op_nop, 1'b0, 5'd1, 4'd1));
        send_word(4'd1, 32'd100);
        send_word(4'd2, 32'd200);
        idle_link(0);
        wait_packets(1);
        check_packet(5'd30, 4'd5, 3, 32'd300);
        report_test("clear_dest", e0);
    endtask

    initial begin
        rst_n    = 1'b0;
        din      = '0;
        resend   = 1'b0;
        ap_start = 1'b0;
        cyc      = 0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        seed     = 32'h81d6;
        test_reset_hold();
        test_sum_path();
        test_resend_stall();
        test_clear_dest();
        test_accumulate_path();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule
